/* Makefile */
VERILATOR ?= verilator
TOP       ?= ethRxTb
FILELIST  ?= ethRx.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* ethRx.f */
hdl/ethMiiPkg.sv
hdl/ethFramePkg.sv
hdl/ethRxStateM.sv
hdl/ethRxCounters.sv
hdl/ethRxByteAsm.sv
hdl/ethRxFrameCheck.sv
hdl/ethRxTop.sv
test/ethRxTb.sv

/* hdl/ethFramePkg.sv */
package ethFramePkg;

        // byte counter width.
        localparam int LenWidth = 16;

        // assembled receive byte, one-cycle strobe.
        typedef struct packed
        {
                logic       valid;
                logic       first;   // first data byte after sfd.
                logic [7:0] data;
        } RxByteT;

        // counter flags fed back to the FSM.
        typedef struct packed
        {
                logic maxFrame;
                logic ifgOk;
        } RxCntFlagsT;

        // end-of-frame status word.
        typedef struct packed
        {
                logic                valid;
                logic                crcError;
                logic                tooLong;
                logic [LenWidth-1:0] length;   // fcs included.
        } RxStatusT;

endpackage

/* hdl/ethMiiPkg.sv */
package ethMiiPkg;

        // receive FSM states, one encoded register.
        typedef enum logic [2:0]
        {
                Idle     = 3'd0,
                Preamble = 3'd1,
                Sfd      = 3'd2,
                Data0    = 3'd3,
                Data1    = 3'd4,
                Drop     = 3'd5
        } RxStateT;

        // preamble nibble, 0101 on the wire.
        localparam logic [3:0] PreambleNibble = 4'h5;

        // last nibble of the start-of-frame delimiter.
        localparam logic [3:0] SfdNibble = 4'hD;

        // minimum inter-frame gap in MRxClk cycles.
        localparam logic [4:0] IfgMinCycles = 5'd24;

        // Reflected CRC-32 register contents after a good FCS has been
        // shifted through, with no final inversion applied.
        localparam logic [31:0] CrcResidue = 32'hDEBB20E3;

endpackage

/* hdl/ethRxByteAsm.sv */
`timescale 1ns/100ps

module ethRxByteAsm
(
        input  logic                MRxClk,
        input  logic                Reset,
        input  ethMiiPkg::RxStateT  State,
        input  logic [3:0]          MRxD,
        output ethFramePkg::RxByteT RxByte
);

        logic [3:0] lowNib;
        logic [7:0] byteData;
        logic       byteValid;
        logic       byteFirst;
        logic       firstPend;

        always_ff @(posedge MRxClk)
        begin
                if (State == ethMiiPkg::Data0)
                        lowNib <= MRxD;
                if (State == ethMiiPkg::Data1)
                        byteData <= {MRxD, lowNib};   // high nibble arrives last.
        end

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        byteValid <= 1'b0;
                        byteFirst <= 1'b0;
                        firstPend <= 1'b0;
                end
                else
                begin
                        byteValid <= (State == ethMiiPkg::Data1);
                        byteFirst <= (State == ethMiiPkg::Data1) && firstPend;
                        if (State == ethMiiPkg::Sfd)
                                firstPend <= 1'b1;
                        else if (State == ethMiiPkg::Data1)
                                firstPend <= 1'b0;
                end
        end

        assign RxByte = '{
                valid: byteValid,
                first: byteFirst,
                data:  byteData
        };

endmodule

/* hdl/ethRxCounters.sv */
`timescale 1ns/100ps

module ethRxCounters
#(
        parameter int MaxFrameLen = 1518
)
(
        input  logic                                MRxClk,
        input  logic                                Reset,
        input  ethMiiPkg::RxStateT                  State,
        output ethFramePkg::RxCntFlagsT             CntFlags,
        output logic [ethFramePkg::LenWidth-1:0]    ByteCnt
);

        localparam logic [ethFramePkg::LenWidth-1:0] MaxLen =
                MaxFrameLen[ethFramePkg::LenWidth-1:0];

        logic [ethFramePkg::LenWidth-1:0]          byteCntNext;
        logic [$bits(ethMiiPkg::IfgMinCycles)-1:0] gapCnt;
        logic [$bits(ethMiiPkg::IfgMinCycles)-1:0] gapCntNext;
        logic                                      inData;

        assign inData = (State == ethMiiPkg::Data0) || (State == ethMiiPkg::Data1);

        always_comb
        begin
                byteCntNext = ByteCnt;
                if (State == ethMiiPkg::Sfd)
                        byteCntNext = '0;
                else if ((State == ethMiiPkg::Data1) && (ByteCnt != MaxLen))
                        byteCntNext = ByteCnt + 1'b1;   // stops at the limit.
        end

        always_comb
        begin
                gapCntNext = gapCnt;
                if (inData)
                        gapCntNext = '0;
                else if (gapCnt != ethMiiPkg::IfgMinCycles)
                        gapCntNext = gapCnt + 1'b1;
        end

        // flags are taken from the next counts so they line up with the counters.
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        ByteCnt  <= '0;
                        gapCnt   <= '0;
                        CntFlags <= '0;
                end
                else
                begin
                        ByteCnt           <= byteCntNext;
                        gapCnt            <= gapCntNext;
                        CntFlags.maxFrame <= (byteCntNext == MaxLen);
                        CntFlags.ifgOk    <= (gapCntNext == ethMiiPkg::IfgMinCycles);
                end
        end

endmodule

/* hdl/ethRxFrameCheck.sv */
`timescale 1ns/100ps

module ethRxFrameCheck
(
        input  logic                             MRxClk,
        input  logic                             Reset,
        input  ethMiiPkg::RxStateT               State,
        input  logic [3:0]                       MRxD,
        input  logic [ethFramePkg::LenWidth-1:0] ByteCnt,
        output ethFramePkg::RxStatusT            RxStatus
);

        localparam logic [31:0] CrcPoly = 32'hEDB88320;   // reflected form.

        logic [31:0] crc;
        logic [31:0] crcNext;
        logic        crcOk;
        logic        inFrame;
        logic        tooLong;

        // one nibble through the reflected crc, bit 0 first.
        function automatic logic [31:0] crcNibble(input logic [31:0] crcIn, input logic [3:0] nib);
                logic [31:0] c;
                c = crcIn;
                for (int i = 0; i < 4; i++)
                        c = (c[0] ^ nib[i]) ? ((c >> 1) ^ CrcPoly) : (c >> 1);
                return c;
        endfunction

        assign crcNext = crcNibble(crc, MRxD);

        always_ff @(posedge MRxClk)
        begin
                if (State == ethMiiPkg::Sfd)
                        crc <= '1;
                else if ((State == ethMiiPkg::Data0) || (State == ethMiiPkg::Data1))
                        crc <= crcNext;
        end

        // The check result is kept at byte boundaries, so the idle nibble seen in
        // Data0 as the carrier drops does not disturb it.
        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                begin
                        crcOk   <= 1'b0;
                        inFrame <= 1'b0;
                        tooLong <= 1'b0;
                end
                else
                begin
                        if (State == ethMiiPkg::Sfd)
                                crcOk <= 1'b0;
                        else if (State == ethMiiPkg::Data1)
                                crcOk <= (crcNext == ethMiiPkg::CrcResidue);
                        if (State == ethMiiPkg::Data0)
                                inFrame <= 1'b1;
                        else if (State == ethMiiPkg::Idle)
                                inFrame <= 1'b0;   // status already out.
                        if (State == ethMiiPkg::Sfd)
                                tooLong <= 1'b0;
                        else if ((State == ethMiiPkg::Drop) && inFrame)
                                tooLong <= 1'b1;
                end
        end

        assign RxStatus = '{
                valid:    inFrame && (State == ethMiiPkg::Idle),
                crcError: !crcOk,
                tooLong:  tooLong,
                length:   ByteCnt
        };

endmodule

/* hdl/ethRxStateM.sv */
`timescale 1ns/100ps

module ethRxStateM
(
        input  logic                   MRxClk,
        input  logic                   Reset,
        input  logic                   MRxDV,
        input  logic [3:0]             MRxD,
        input  logic                   Transmitting,
        input  ethFramePkg::RxCntFlagsT CntFlags,
        output ethMiiPkg::RxStateT     State
);

        ethMiiPkg::RxStateT nextState;
        logic               nibEq5;
        logic               nibEqD;

        assign nibEq5 = (MRxD == ethMiiPkg::PreambleNibble);
        assign nibEqD = (MRxD == ethMiiPkg::SfdNibble);

        always_comb
        begin
                nextState = State;
                if (!MRxDV)
                begin
                        nextState = ethMiiPkg::Idle;   // line went quiet.
                end
                else
                begin
                        unique case (State)
                                ethMiiPkg::Idle:
                                begin
                                        if (Transmitting)
                                                nextState = ethMiiPkg::Drop;
                                        else if (nibEq5)
                                                nextState = ethMiiPkg::Sfd;
                                        else
                                                nextState = ethMiiPkg::Preamble;
                                end
                                ethMiiPkg::Preamble:
                                begin
                                        if (nibEq5)
                                                nextState = ethMiiPkg::Sfd;
                                end
                                ethMiiPkg::Sfd:
                                begin
                                        if (nibEqD && CntFlags.ifgOk)
                                                nextState = ethMiiPkg::Data0;
                                        else if (nibEqD)
                                                nextState = ethMiiPkg::Drop;   // gap too short.
                                end
                                ethMiiPkg::Data0:
                                begin
                                        if (CntFlags.maxFrame)
                                                nextState = ethMiiPkg::Drop;
                                        else
                                                nextState = ethMiiPkg::Data1;
                                end
                                ethMiiPkg::Data1:
                                        nextState = ethMiiPkg::Data0;
                                ethMiiPkg::Drop:
                                        nextState = ethMiiPkg::Drop;   // wait for end of carrier.
                                default:
                                        nextState = ethMiiPkg::Drop;
                        endcase
                end
        end

        always_ff @(posedge MRxClk or posedge Reset)
        begin
                if (Reset)
                        State <= ethMiiPkg::Drop;
                else
                        State <= nextState;
        end

endmodule

/* hdl/ethRxTop.sv */
`timescale 1ns/100ps

module ethRxTop
#(
        parameter int MaxFrameLen = 1518
)
(
        input  logic                  MRxClk,
        input  logic                  Reset,
        input  logic                  MRxDV,
        input  logic [3:0]            MRxD,
        input  logic                  Transmitting,
        output ethFramePkg::RxByteT   RxByte,
        output ethFramePkg::RxStatusT RxStatus
);

        ethMiiPkg::RxStateT               state;
        ethFramePkg::RxCntFlagsT          cntFlags;
        logic [ethFramePkg::LenWidth-1:0] byteCnt;

        ethRxStateM iStateM
        (
                .MRxClk       (MRxClk),
                .Reset        (Reset),
                .MRxDV        (MRxDV),
                .MRxD         (MRxD),
                .Transmitting (Transmitting),
                .CntFlags     (cntFlags),
                .State        (state)
        );

        ethRxCounters
        #(
                .MaxFrameLen (MaxFrameLen)
        )
        iCounters
        (
                .MRxClk   (MRxClk),
                .Reset    (Reset),
                .State    (state),
                .CntFlags (cntFlags),
                .ByteCnt  (byteCnt)
        );

        ethRxByteAsm iByteAsm
        (
                .MRxClk (MRxClk),
                .Reset  (Reset),
                .State  (state),
                .MRxD   (MRxD),
                .RxByte (RxByte)
        );

        ethRxFrameCheck iFrameCheck
        (
                .MRxClk   (MRxClk),
                .Reset    (Reset),
                .State    (state),
                .MRxD     (MRxD),
                .ByteCnt  (byteCnt),
                .RxStatus (RxStatus)
        );

endmodule

/* test/ethRxTb.sv */
`timescale 1ns/100ps

module ethRxTb;

        logic                  MRxClk;
        logic                  Reset;
        logic                  MRxDV;
        logic [3:0]            MRxD;
        logic                  Transmitting;
        ethFramePkg::RxByteT   RxByte;
        ethFramePkg::RxStatusT RxStatus;

        ethFramePkg::RxByteT   byteQ[$];
        ethFramePkg::RxStatusT statusQ[$];
        logic [7:0]            txBytes[$];
        int                    errors;
        int                    frames;

        ethRxTop #(.MaxFrameLen(64)) i_dut
        (
                .MRxClk       (MRxClk),
                .Reset        (Reset),
                .MRxDV        (MRxDV),
                .MRxD         (MRxD),
                .Transmitting (Transmitting),
                .RxByte       (RxByte),
                .RxStatus     (RxStatus)
        );

        always #2 MRxClk = ~MRxClk;

        always @(negedge MRxClk)   // strobes are stable here.
        begin
                if (RxByte.valid)
                        byteQ.push_back(RxByte);
                if (RxStatus.valid)
                        statusQ.push_back(RxStatus);
        end

        // crc-32 over the first len bytes, bytewise, lsb first.
        function automatic logic [31:0] fcsOf(input int len);
                logic [31:0] crc;
                crc = 32'hFFFFFFFF;
                for (int i = 0; i < len; i++)
                begin
                        crc = crc ^ {24'd0, txBytes[i]};
                        for (int b = 0; b < 8; b++)
                                crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
                end
                return ~crc;
        endfunction

        task automatic buildFrame(input int payLen, input bit corrupt);
                logic [31:0] fcs;
                txBytes.delete();
                for (int i = 0; i < payLen; i++)
                        txBytes.push_back(8'($urandom));
                fcs = fcsOf(payLen);
                if (corrupt)
                        fcs[5] = ~fcs[5];
                for (int i = 0; i < 4; i++)
                        txBytes.push_back(fcs[8*i +: 8]);   // fcs goes out low byte first.
        endtask

        task automatic driveNibble(input logic [3:0] nib);
                @(posedge MRxClk);
                MRxDV <= 1'b1;
                MRxD  <= nib;
        endtask

        task automatic sendFrame(input int preBytes);
                for (int i = 0; i < 2 * preBytes; i++)
                        driveNibble(4'h5);
                driveNibble(4'h5);
                driveNibble(4'hD);
                foreach (txBytes[i])
                begin
                        driveNibble(txBytes[i][3:0]);
                        driveNibble(txBytes[i][7:4]);
                end
                @(posedge MRxClk);
                MRxDV <= 1'b0;
                MRxD  <= 4'h0;
        endtask

        task automatic clearQueues();
                byteQ.delete();
                statusQ.delete();
        endtask

        task automatic reportValue(input string name, input string what,
                                   input longint expVal, input longint actVal);
                errors++;
                $display("[ERROR] %s: %s expected %0h, actual %0h", name, what, expVal, actVal);
        endtask

        task automatic checkFrame(input string name, input int expCount,
                                  input logic expCrcErr, input logic expTooLong);
                int cyc;
                cyc = 0;
                while ((statusQ.size() == 0) && (cyc < 400))
                begin
                        @(posedge MRxClk);
                        cyc++;
                end
                if (statusQ.size() == 0)
                begin
                        errors++;
                        $display("%s: no frame status arrived within 400 cycles", name);
                        return;
                end
                frames++;
                repeat (4) @(posedge MRxClk);   // a repeated status would land here.
                if (byteQ.size() != expCount)
                        reportValue(name, "byte count", expCount, byteQ.size());
                for (int i = 0; (i < expCount) && (i < byteQ.size()); i++)
                begin
                        if (byteQ[i].data != txBytes[i])
                                reportValue(name, $sformatf("byte %0d", i), txBytes[i], byteQ[i].data);
                        if (byteQ[i].first != (i == 0))
                                reportValue(name, $sformatf("first of byte %0d", i), i == 0,
                                            byteQ[i].first);
                end
                if (statusQ.size() != 1)
                        reportValue(name, "status count", 1, statusQ.size());
                if (statusQ[0].length != expCount)
                        reportValue(name, "length", expCount, statusQ[0].length);
                if (statusQ[0].crcError != expCrcErr)
                        reportValue(name, "crcError", expCrcErr, statusQ[0].crcError);
                if (statusQ[0].tooLong != expTooLong)
                        reportValue(name, "tooLong", expTooLong, statusQ[0].tooLong);
        endtask

        task automatic expectNothing(input string name, input int n);
                repeat (n) @(posedge MRxClk);
                if (byteQ.size() != 0)
                        reportValue(name, "byte count", 0, byteQ.size());
                if (statusQ.size() != 0)
                        reportValue(name, "status count", 0, statusQ.size());
        endtask

        task automatic receiveFrame(input string name, input int payLen, input int preBytes,
                                    input bit corrupt, input int expCount, input logic expTooLong);
                repeat (30) @(posedge MRxClk);   // full inter-frame gap.
                clearQueues();
                buildFrame(payLen, corrupt);
                sendFrame(preBytes);
                checkFrame(name, expCount, corrupt || expTooLong, expTooLong);
        endtask

        task automatic shortGapTest();
                receiveFrame("shortGap lead", 12, 7, 1'b0, 16, 1'b0);
                clearQueues();
                buildFrame(12, 1'b0);
                sendFrame(0);   // sfd lands a few cycles after the last one.
                expectNothing("shortGap", 40);
                receiveFrame("shortGap recover", 16, 7, 1'b0, 20, 1'b0);
                receiveFrame("noPreamble", 16, 0, 1'b0, 20, 1'b0);
        endtask

        task automatic transmittingTest();
                repeat (30) @(posedge MRxClk);
                clearQueues();
                Transmitting <= 1'b1;
                buildFrame(20, 1'b0);
                sendFrame(7);
                expectNothing("transmitting", 40);
                Transmitting <= 1'b0;
        endtask

        initial
        begin
                MRxClk       = 1'b0;
                Reset        = 1'b1;
                MRxDV        = 1'b0;
                MRxD         = 4'h0;
                Transmitting = 1'b0;
                errors       = 0;
                frames       = 0;
                void'($urandom(32'h533d));
                repeat (5) @(posedge MRxClk);
                Reset <= 1'b0;
                receiveFrame("goodFrame", 20, 7, 1'b0, 24, 1'b0);
                receiveFrame("badFcs", 20, 7, 1'b1, 24, 1'b0);
                shortGapTest();
                transmittingTest();
                receiveFrame("oversize", 80, 7, 1'b0, 64, 1'b1);
                $display("frames checked: %0d, errors: %0d", frames, errors);
                if (errors == 0)
                        $display("Test passed");
                else
                        $display("Test failed");
                $finish;
        end

endmodule
